// ==== flist.f ====
+incdir+include
rtl/cache_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/l1_dcache.sv
bench/clk_gen.sv
bench/tb_l1_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the L1 data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_l1_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_l1_dcache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
exit 1

// ==== bench/tb_l1_dcache.sv ====
//====================================================================
// L1 data cache testbench with random accesses checked against a model
//====================================================================
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_l1_dcache;

  localparam int NUM_ACCESSES = 200;
  localparam int CLK_NS       = 4;
  localparam int WATCHDOG_NS  = CLK_NS * NUM_ACCESSES * 40; // 40 cycles per access
  localparam logic [`CACHE_TAG_BITS-1:0] TAG_BASE = 22'h2a_5c10;

  logic                   clk;
  logic                   rst;
  mem_bus_pkg::core_req_t core_req;
  mem_bus_pkg::core_rsp_t core_rsp;
  mem_bus_pkg::mem_req_t  mem_req;
  mem_bus_pkg::mem_rsp_t  mem_rsp;

  // reference model of the cache contents
  logic [`CACHE_TAG_BITS-1:0] model_tag   [`CACHE_LINES];
  logic                       model_valid [`CACHE_LINES];
  cache_types_pkg::word_t     model_line  [`CACHE_LINES][`CACHE_WORDS_PER_LINE];
  cache_types_pkg::word_t     mem_words   [logic [`CACHE_ADDR_BITS-3:0]]; // stored words
  mem_bus_pkg::mem_req_t      seen_reqs   [$]; // memory requests of this access

  int errors;
  int tests_run;
  int tests_failed;

  clk_gen clk_gen_i (.clk(clk), .rst(rst));

  l1_dcache l1_dcache_i (
    .clk      (clk),
    .rst      (rst),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  //==================================================================
  // memory and lane helpers
  //==================================================================
  // words never written hash from their word address
  function automatic cache_types_pkg::word_t fill_pattern(input cache_types_pkg::word_t addr);
    return ({addr[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'h3c6e_f372;
  endfunction

  function automatic cache_types_pkg::word_t mem_read(input cache_types_pkg::word_t addr);
    if (mem_words.exists(addr[31:2])) begin
      return mem_words[addr[31:2]];
    end
    return fill_pattern(addr);
  endfunction

  // misaligned stores touch no byte lane
  function automatic logic [3:0] lane_mask(input cache_types_pkg::access_type_e t,
                                           input logic [1:0] off);
    case (t)
      cache_types_pkg::acc_byte, cache_types_pkg::acc_byte_u: return 4'b0001 << off;
      cache_types_pkg::acc_hword, cache_types_pkg::acc_hword_u:
        return (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
      cache_types_pkg::acc_word: return (off == 2'd0) ? 4'b1111 : 4'b0000;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic cache_types_pkg::word_t merge_lanes(input cache_types_pkg::word_t old,
                                                         input cache_types_pkg::word_t data,
                                                         input logic [3:0] be);
    cache_types_pkg::word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = data[b*8 +: 8]; // data already in its lane
    end
    return res;
  endfunction

  function automatic cache_types_pkg::access_type_e pick_access(input int unsigned k);
    case (k)
      0: return cache_types_pkg::acc_byte;
      1: return cache_types_pkg::acc_hword;
      2: return cache_types_pkg::acc_word;
      3: return cache_types_pkg::acc_byte_u;
      default: return cache_types_pkg::acc_hword_u;
    endcase
  endfunction

  //==================================================================
  // compare tasks
  //==================================================================
  task automatic check_word(input string name, input cache_types_pkg::word_t exp,
                            input cache_types_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mem_req(input string name, input mem_bus_pkg::mem_req_t exp,
                               input mem_bus_pkg::mem_req_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // every cycle with req high counts as one memory request
  always @(negedge clk) begin
    if (!rst && mem_req.req) begin
      seen_reqs.push_back(mem_req);
    end
  end

  //==================================================================
  // memory responder with 0 to 3 busy cycles per transfer
  //==================================================================
  initial begin : mem_responder
    mem_bus_pkg::mem_req_t cur;
    int                    busy_cycles;
    mem_rsp = '0;
    forever begin
      @(negedge clk);
      if (!rst && mem_req.req) begin
        cur = mem_req;
        busy_cycles = $urandom % 4;
        repeat (busy_cycles) begin
          @(posedge clk);
          #1;
          mem_rsp.busy = 1'b1;
        end
        @(posedge clk);
        #1;
        mem_rsp.busy = 1'b0; // completion cycle
        if (cur.write) begin
          mem_words[cur.addr[31:2]] = merge_lanes(mem_read(cur.addr), cur.wdata,
                                                  lane_mask(cur.acc_type, cur.addr[1:0]));
        end else begin
          mem_rsp.rdata = mem_read(cur.addr);
        end
        @(posedge clk);
        #1;
        mem_rsp.rdata = '0;
      end
    end
  end

  //==================================================================
  // one random access driven at posedge + 1 ns
  //==================================================================
  task automatic run_access(input int n);
    mem_bus_pkg::core_req_t req;
    mem_bus_pkg::mem_req_t  exp_req;
    cache_types_pkg::word_t rdata;
    logic                   hit;
    int                     errs_before;
    string                  name;
    req                   = '0;
    req.req               = 1'b1;
    req.write             = ($urandom % 5) < 2;
    req.addr.tag          = TAG_BASE + 22'($urandom % 3); // small pool so conflicts are likely
    req.addr.index        = 6'(3 + 13 * ($urandom % 4));
    req.addr.word         = 2'($urandom);
    req.addr.byte_off     = 2'($urandom);
    req.wdata             = $urandom;
    req.acc_type          = pick_access($urandom % 5);
    hit  = model_valid[req.addr.index] && (model_tag[req.addr.index] == req.addr.tag);
    name = $sformatf("access %0d %s %s", n, req.write ? "store" : "load", hit ? "hit" : "miss");
    errs_before = errors;

    core_req = req;
    do begin
      @(negedge clk); // outputs settled mid cycle
    end while (core_rsp.stall);
    rdata = core_rsp.rdata;
    @(posedge clk);
    #1;
    core_req = '0;

    if (req.write) begin
      check_count({name, " request count"}, 1, seen_reqs.size());
      exp_req          = '0;
      exp_req.req      = 1'b1;
      exp_req.write    = 1'b1;
      exp_req.addr     = req.addr;
      exp_req.wdata    = req.wdata;
      exp_req.acc_type = req.acc_type;
      if (seen_reqs.size() > 0) check_mem_req({name, " store request"}, exp_req, seen_reqs[0]);
      if (hit) begin // no allocate on a miss
        model_line[req.addr.index][req.addr.word] =
          merge_lanes(model_line[req.addr.index][req.addr.word], req.wdata,
                      lane_mask(req.acc_type, req.addr.byte_off));
      end
    end else begin
      if (hit) begin
        check_count({name, " request count"}, 0, seen_reqs.size());
      end else begin
        check_count({name, " request count"}, 4, seen_reqs.size());
        for (int k = 0; k < `CACHE_WORDS_PER_LINE; k++) begin
          exp_req          = '0;
          exp_req.req      = 1'b1;
          exp_req.addr     = {req.addr.tag, req.addr.index, 2'(k), 2'b00};
          exp_req.acc_type = cache_types_pkg::acc_word;
          if (k < seen_reqs.size()) begin
            check_mem_req($sformatf("%s refill %0d", name, k), exp_req, seen_reqs[k]);
          end
          model_line[req.addr.index][k] = mem_read(exp_req.addr);
        end
        model_valid[req.addr.index] = 1'b1;
        model_tag[req.addr.index]   = req.addr.tag;
      end
      check_word({name, " read data"}, model_line[req.addr.index][req.addr.word], rdata);
    end
    seen_reqs.delete(); // leftovers would show in the next count
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: error", name);
    end
  endtask

  //==================================================================
  // main sequence
  //==================================================================
  initial begin
    core_req     = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < `CACHE_LINES; i++) begin
      model_valid[i] = 1'b0; // matches reset of the valid bits
    end
    void'($urandom(32'h2f45_5e18));
    @(negedge rst);
    repeat (2) begin
      @(negedge clk);
      check_count("reset stall", 0, int'(core_rsp.stall));
      check_count("reset memory request", 0, int'(mem_req.req));
    end
    tests_run++;
    if (errors == 0) begin
      $display("reset: ok");
    end else begin
      tests_failed++;
      $display("reset: error");
    end
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_ACCESSES; n++) begin
      run_access(n);
      repeat ($urandom % 2) begin // idle gap or back to back
        @(posedge clk);
        #1;
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, an access never finished", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== bench/clk_gen.sv ====
//====================================================================
// testbench clock, 4 ns period, and reset for the first 4 cycles
//====================================================================
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // half period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0; // released off the edge like other inputs
  end

endmodule

// ==== rtl/l1_dcache.sv ====
//====================================================================
// L1 data cache top, direct mapped, write-through, no write allocate
//====================================================================
`timescale 1ns/1ps
`include "cache_consts.svh"

module l1_dcache (
  input  logic                   clk,
  input  logic                   rst,
  input  mem_bus_pkg::core_req_t core_req,
  output mem_bus_pkg::core_rsp_t core_rsp,
  output mem_bus_pkg::mem_req_t  mem_req,
  input  mem_bus_pkg::mem_rsp_t  mem_rsp
);

  logic                            hit;
  cache_types_pkg::word_t          rd_word;
  logic                            store_en;
  logic                            fill_en;
  logic                            set_line;
  logic [`CACHE_WORD_SEL_BITS-1:0] fill_word;

  // tag and line arrays look up the same address in parallel
  tag_store tag_store_i (
    .clk      (clk),
    .rst      (rst),
    .addr     (core_req.addr),
    .set_line (set_line),
    .hit      (hit)
  );

  line_store line_store_i (
    .clk       (clk),
    .addr      (core_req.addr),
    .store_en  (store_en),
    .acc_type  (core_req.acc_type),
    .wdata     (core_req.wdata),
    .fill_en   (fill_en),
    .fill_word (fill_word),
    .fill_data (mem_rsp.rdata), // refill word straight from memory
    .rd_word   (rd_word)
  );

  cache_ctrl cache_ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .hit       (hit),
    .rd_word   (rd_word),
    .mem_rsp   (mem_rsp),
    .core_rsp  (core_rsp),
    .mem_req   (mem_req),
    .store_en  (store_en),
    .fill_en   (fill_en),
    .set_line  (set_line),
    .fill_word (fill_word)
  );

endmodule

// ==== rtl/cache_ctrl.sv ====
//====================================================================
// cache controller FSM: lookup, write-through store, line refill
//====================================================================
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  mem_bus_pkg::core_req_t          core_req,
  input  logic                            hit,
  input  cache_types_pkg::word_t          rd_word,
  input  mem_bus_pkg::mem_rsp_t           mem_rsp,
  output mem_bus_pkg::core_rsp_t          core_rsp,
  output mem_bus_pkg::mem_req_t           mem_req,
  output logic                            store_en,
  output logic                            fill_en,
  output logic                            set_line,
  output logic [`CACHE_WORD_SEL_BITS-1:0] fill_word
);

  cache_types_pkg::ctrl_state_e    state, next_state;
  logic [`CACHE_WORD_SEL_BITS-1:0] cnt;         // refill word counter
  logic                            refill_done; // one refill word back
  cache_types_pkg::cache_addr_t    refill_addr;

  //==================================================================
  // state and counter
  //==================================================================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= cache_types_pkg::st_idle;
      cnt   <= '0;
    end else begin
      state <= next_state;
      if (refill_done) begin
        cnt <= cnt + 1'b1; // wraps to 0 after the last word
      end
    end
  end

  assign refill_done = (state == cache_types_pkg::st_refill_wait) && !mem_rsp.busy;

  always_comb begin
    next_state = state;
    case (state)
      cache_types_pkg::st_idle:
        if (core_req.req) next_state = cache_types_pkg::st_lookup;
      cache_types_pkg::st_lookup:
        if (core_req.write) next_state = cache_types_pkg::st_store_req; // hit or miss
        else if (hit)       next_state = cache_types_pkg::st_done;
        else                next_state = cache_types_pkg::st_refill_req;
      cache_types_pkg::st_store_req:  next_state = cache_types_pkg::st_store_wait;
      cache_types_pkg::st_store_wait:
        if (!mem_rsp.busy) next_state = cache_types_pkg::st_done;
      cache_types_pkg::st_refill_req: next_state = cache_types_pkg::st_refill_wait;
      cache_types_pkg::st_refill_wait:
        if (refill_done) begin
          next_state = (&cnt) ? cache_types_pkg::st_reread
                              : cache_types_pkg::st_refill_req;
        end
      cache_types_pkg::st_reread: next_state = cache_types_pkg::st_done;
      default: next_state = cache_types_pkg::st_idle; // st_done included
    endcase
  end

  //==================================================================
  // array controls
  //==================================================================
  assign store_en  = (state == cache_types_pkg::st_lookup) && core_req.write && hit;
  assign fill_en   = refill_done;
  assign set_line  = refill_done && (&cnt); // tag goes in with the last word
  assign fill_word = cnt;

  // word n of the missing line
  always_comb begin
    refill_addr          = core_req.addr;
    refill_addr.word     = cnt;
    refill_addr.byte_off = '0;
  end

  //==================================================================
  // memory request
  //==================================================================
  always_comb begin
    mem_req = '0;
    if (state == cache_types_pkg::st_refill_req || state == cache_types_pkg::st_refill_wait) begin
      mem_req.addr     = refill_addr;
      mem_req.acc_type = cache_types_pkg::acc_word;
    end else if (state == cache_types_pkg::st_store_req ||
                 state == cache_types_pkg::st_store_wait) begin
      mem_req.write    = 1'b1;
      mem_req.addr     = core_req.addr; // store forwarded as is
      mem_req.wdata    = core_req.wdata;
      mem_req.acc_type = core_req.acc_type;
    end
    mem_req.req = (state == cache_types_pkg::st_store_req) ||
                  (state == cache_types_pkg::st_refill_req);
  end

  // core response, finishing cycle is st_done
  assign core_rsp.stall = core_req.req && (state != cache_types_pkg::st_done);
  assign core_rsp.rdata = (state == cache_types_pkg::st_done && !core_req.write) ? rd_word : '0;

endmodule

// ==== rtl/line_store.sv ====
//====================================================================
// line data array, byte lane store merge, word refill, word read
//====================================================================
`timescale 1ns/1ps
`include "cache_consts.svh"

module line_store (
  input  logic                            clk,
  input  cache_types_pkg::cache_addr_t    addr,
  input  logic                            store_en,
  input  cache_types_pkg::access_type_e   acc_type,
  input  cache_types_pkg::word_t          wdata,
  input  logic                            fill_en,
  input  logic [`CACHE_WORD_SEL_BITS-1:0] fill_word,
  input  cache_types_pkg::word_t          fill_data,
  output cache_types_pkg::word_t          rd_word
);

  localparam int WORD_BYTES = `CACHE_ADDR_BITS / 8;

  cache_types_pkg::line_t lines [`CACHE_LINES]; // plain array, no reset

  logic [WORD_BYTES-1:0]     lane_be; // enables inside the addressed word
  cache_types_pkg::line_be_t wr_be;
  cache_types_pkg::line_t    wr_data;

  // which byte lanes a store may touch, misaligned stores touch none
  always_comb begin
    lane_be = '0;
    case (acc_type)
      cache_types_pkg::acc_byte, cache_types_pkg::acc_byte_u:
        lane_be = 4'b0001 << addr.byte_off;
      cache_types_pkg::acc_hword, cache_types_pkg::acc_hword_u:
        if (!addr.byte_off[0]) begin
          lane_be = addr.byte_off[1] ? 4'b1100 : 4'b0011;
        end
      cache_types_pkg::acc_word:
        if (addr.byte_off == '0) begin
          lane_be = 4'b1111;
        end
      default: lane_be = '0;
    endcase
  end

  // data copied into every word slot, enables pick the one that lands
  always_comb begin
    wr_be   = '0;
    wr_data = '0;
    for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
      if (fill_en) begin
        wr_data[w*`CACHE_ADDR_BITS +: `CACHE_ADDR_BITS] = fill_data;
        if (int'(fill_word) == w) begin
          wr_be[w*WORD_BYTES +: WORD_BYTES] = '1; // whole word from memory
        end
      end else if (store_en) begin
        wr_data[w*`CACHE_ADDR_BITS +: `CACHE_ADDR_BITS] = wdata;
        if (int'(addr.word) == w) begin
          wr_be[w*WORD_BYTES +: WORD_BYTES] = lane_be;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `CACHE_LINE_BITS / 8; b++) begin
      if (wr_be[b]) begin
        lines[addr.index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
    // read sees the line as it was before this edge
    rd_word <= lines[addr.index][addr.word*`CACHE_ADDR_BITS +: `CACHE_ADDR_BITS];
  end

endmodule

// ==== rtl/tag_store.sv ====
//====================================================================
// tag array with valid bits, registered lookup and hit compare
//====================================================================
`timescale 1ns/1ps
`include "cache_consts.svh"

module tag_store (
  input  logic                         clk,
  input  logic                         rst,
  input  cache_types_pkg::cache_addr_t addr,
  input  logic                         set_line, // install tag, mark valid
  output logic                         hit
);

  logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_LINES]; // no reset needed
  logic [`CACHE_LINES-1:0]    valid;

  logic [`CACHE_TAG_BITS-1:0] tag_q;   // registered tag read
  logic                       valid_q; // registered valid read

  //==================================================================
  // valid bits
  //==================================================================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid[addr.index]; // old value on a set edge
      if (set_line) begin
        valid[addr.index] <= 1'b1;
      end
    end
  end

  //==================================================================
  // tag array
  //==================================================================
  always_ff @(posedge clk) begin
    tag_q <= tags[addr.index];
    if (set_line) begin
      tags[addr.index] <= addr.tag;
    end
  end

  // compare against the live tag, core holds addr through the access
  assign hit = valid_q && (tag_q == addr.tag);

endmodule

// ==== rtl/mem_bus_pkg.sv ====
//====================================================================
// core side and memory side bus structs of the data cache
//====================================================================

package mem_bus_pkg;

  // core to cache, held stable while req is high
  typedef struct packed {
    logic                        req;
    logic                        write;    // high for a store
    cache_types_pkg::cache_addr_t addr;
    cache_types_pkg::word_t      wdata;    // already placed in its byte lanes
    cache_types_pkg::access_type_e acc_type;
  } core_req_t;

  // cache to core
  typedef struct packed {
    cache_types_pkg::word_t rdata; // zero outside the finishing cycle
    logic                   stall;
  } core_rsp_t;

  // cache to memory, req is a single cycle pulse
  typedef struct packed {
    logic                          req;
    logic                          write;
    cache_types_pkg::word_t        addr;
    cache_types_pkg::word_t        wdata;
    cache_types_pkg::access_type_e acc_type;
  } mem_req_t;

  // memory to cache
  typedef struct packed {
    cache_types_pkg::word_t rdata; // valid in first non-busy cycle
    logic                   busy;
  } mem_rsp_t;

endpackage

// ==== rtl/cache_types_pkg.sv ====
//====================================================================
// cache internal types: address split, line, byte enables, enums
//====================================================================
`include "cache_consts.svh"

package cache_types_pkg;

  typedef logic [`CACHE_ADDR_BITS-1:0] word_t; // one data word

  // address as the cache sees it, tag on top
  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]      tag;
    logic [`CACHE_INDEX_BITS-1:0]    index;
    logic [`CACHE_WORD_SEL_BITS-1:0] word;
    logic [`CACHE_BYTE_OFF_BITS-1:0] byte_off;
  } cache_addr_t;

  typedef logic [`CACHE_LINE_BITS-1:0] line_t;
  typedef logic [`CACHE_LINE_BITS/8-1:0] line_be_t; // one bit per line byte

  // access size, same codes the core puts on its type bus
  typedef enum logic [2:0] {
    acc_byte    = 3'b000,
    acc_hword   = 3'b001,
    acc_word    = 3'b010,
    acc_byte_u  = 3'b100,
    acc_hword_u = 3'b101
  } access_type_e;

  // controller FSM
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,      // tag and data reads valid here
    st_store_req,
    st_store_wait,
    st_refill_req,
    st_refill_wait,
    st_reread,      // line just filled, read word again
    st_done
  } ctrl_state_e;

endpackage

// ==== include/cache_consts.svh ====
//====================================================================
// cache geometry and address field widths for the L1 data cache
//====================================================================
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address and data path width
`define CACHE_ADDR_BITS 32

// line count and index
`define CACHE_LINES 64
`define CACHE_INDEX_BITS 6 // log2 of line count

// words in a line and the select field
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WORD_SEL_BITS 2

// byte offset inside a word
`define CACHE_BYTE_OFF_BITS 2

// what is left of the address above index, word and byte offset
`define CACHE_TAG_BITS 22

// full line width, four 32-bit words
`define CACHE_LINE_BITS 128

`endif
